// File: logic/cpu_pkg.sv
package cpu_pkg;

    // Datapath and register index widths
    localparam int xlen     = 32;
    localparam int reg_aw   = 5;
    localparam int alu_op_w = 3;

    // Major opcodes of the supported subset
    localparam logic [6:0] op_rtype  = 7'b0110011;
    localparam logic [6:0] op_itype  = 7'b0010011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;

    // funct3 and funct7 codes
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;
    localparam logic [2:0] f3_beq     = 3'b000;
    localparam logic [6:0] f7_sub     = 7'b0100000;

    typedef enum logic [alu_op_w-1:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_slt
    } alu_op_t;

    typedef struct packed {
        logic [6:0]        funct7;
        logic [reg_aw-1:0] rs2;
        logic [reg_aw-1:0] rs1;
        logic [2:0]        funct3;
        logic [reg_aw-1:0] rd;
        logic [6:0]        opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]       imm;
        logic [reg_aw-1:0] rs1;
        logic [2:0]        funct3;
        logic [reg_aw-1:0] rd;
        logic [6:0]        opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0]        imm_hi;
        logic [reg_aw-1:0] rs2;
        logic [reg_aw-1:0] rs1;
        logic [2:0]        funct3;
        logic [4:0]        imm_lo;
        logic [6:0]        opcode;
    } s_fmt_t;

    // Branch offset bits are scattered, bit 0 is implied zero
    typedef struct packed {
        logic              imm_12;
        logic [5:0]        imm_10_5;
        logic [reg_aw-1:0] rs2;
        logic [reg_aw-1:0] rs1;
        logic [2:0]        funct3;
        logic [3:0]        imm_4_1;
        logic              imm_11;
        logic [6:0]        opcode;
    } b_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
    } rv_inst_t;

endpackage

// File: logic/ex_stage.sv
`timescale 1ns/100ps

module ex_stage import cpu_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              flush,
    input  logic              ex_valid,
    input  logic [xlen-1:0]   ex_pc,
    input  logic [reg_aw-1:0] ex_rs1,
    input  logic [reg_aw-1:0] ex_rs2,
    input  logic [reg_aw-1:0] ex_rd,
    input  logic [xlen-1:0]   ex_imm,
    input  logic [xlen-1:0]   ex_rdata1,
    input  logic [xlen-1:0]   ex_rdata2,
    input  alu_op_t           ex_alu_op,
    input  logic              ex_alu_src_imm,
    input  logic              ex_mem_read,
    input  logic              ex_mem_write,
    input  logic              ex_branch,
    input  logic              ex_reg_write,
    input  logic              wb_valid,
    input  logic [reg_aw-1:0] wb_rd,
    input  logic [xlen-1:0]   wb_data,
    output logic              mem_valid,
    output logic [xlen-1:0]   mem_alu_result,
    output logic [xlen-1:0]   mem_store_data,
    output logic [xlen-1:0]   mem_target,
    output logic              mem_zero,
    output logic [reg_aw-1:0] mem_rd,
    output logic              mem_mem_read,
    output logic              mem_mem_write,
    output logic              mem_branch,
    output logic              mem_reg_write
);

    logic            mem_fwd_ok;
    logic [xlen-1:0] fwd_a;
    logic [xlen-1:0] fwd_b;
    logic [xlen-1:0] op_b;
    logic [xlen-1:0] result;

    // A load in EX/MEM has no data yet, the stall covers that case
    assign mem_fwd_ok = mem_valid && mem_reg_write && !mem_mem_read && mem_rd != '0;

    always_comb begin
        if (mem_fwd_ok && mem_rd == ex_rs1) begin
            fwd_a = mem_alu_result;
        end else if (wb_valid && wb_rd == ex_rs1) begin
            fwd_a = wb_data;
        end else begin
            fwd_a = ex_rdata1;
        end
    end

    always_comb begin
        if (mem_fwd_ok && mem_rd == ex_rs2) begin
            fwd_b = mem_alu_result;
        end else if (wb_valid && wb_rd == ex_rs2) begin
            fwd_b = wb_data;
        end else begin
            fwd_b = ex_rdata2;
        end
    end

    assign op_b = ex_alu_src_imm ? ex_imm : fwd_b;

    always_comb begin
        case (ex_alu_op)
            alu_add: result = fwd_a + op_b;
            alu_sub: result = fwd_a - op_b;
            alu_and: result = fwd_a & op_b;
            alu_or:  result = fwd_a | op_b;
            alu_slt: result = {{(xlen-1){1'b0}}, $signed(fwd_a) < $signed(op_b)};
            default: result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mem_valid <= 1'b0;
        end else begin
            mem_valid <= ex_valid && !flush;
        end
    end

    always_ff @(posedge clk) begin
        if (!flush) begin
            mem_alu_result <= result;
            mem_store_data <= fwd_b;
            mem_target     <= ex_pc + ex_imm;
            mem_zero       <= (result == '0);
            mem_rd         <= ex_rd;
            mem_mem_read   <= ex_mem_read;
            mem_mem_write  <= ex_mem_write;
            mem_branch     <= ex_branch;
            mem_reg_write  <= ex_reg_write;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        ex_valid |-> ex_alu_op inside {alu_add, alu_sub, alu_and, alu_or, alu_slt});

endmodule

// File: logic/id_stage.sv
`timescale 1ns/100ps

module id_stage import cpu_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              id_valid,
    input  logic [xlen-1:0]   id_pc,
    input  logic [xlen-1:0]   id_inst,
    input  logic              flush,
    input  logic              wb_valid,
    input  logic [reg_aw-1:0] wb_rd,
    input  logic [xlen-1:0]   wb_data,
    output logic              stall,
    output logic              ex_valid,
    output logic [xlen-1:0]   ex_pc,
    output logic [reg_aw-1:0] ex_rs1,
    output logic [reg_aw-1:0] ex_rs2,
    output logic [reg_aw-1:0] ex_rd,
    output logic [xlen-1:0]   ex_imm,
    output logic [xlen-1:0]   ex_rdata1,
    output logic [xlen-1:0]   ex_rdata2,
    output alu_op_t           ex_alu_op,
    output logic              ex_alu_src_imm,
    output logic              ex_mem_read,
    output logic              ex_mem_write,
    output logic              ex_branch,
    output logic              ex_reg_write
);

    rv_inst_t          inst;
    logic [reg_aw-1:0] rs1;
    logic [reg_aw-1:0] rs2;
    logic [xlen-1:0]   imm;
    logic [xlen-1:0]   rdata1;
    logic [xlen-1:0]   rdata2;
    alu_op_t           alu_op;
    logic              alu_src_imm;
    logic              mem_read;
    logic              mem_write;
    logic              branch;
    logic              reg_write;
    logic [xlen-1:0]   regs [32];

    assign inst = id_inst;
    assign rs1  = inst.r_fmt.rs1;
    assign rs2  = inst.r_fmt.rs2;

    // Sign-extended immediate per format
    always_comb begin
        case (inst.r_fmt.opcode)
            op_itype, op_load: imm = {{20{inst.i_fmt.imm[11]}}, inst.i_fmt.imm};
            op_store: imm = {{20{inst.s_fmt.imm_hi[6]}}, inst.s_fmt.imm_hi, inst.s_fmt.imm_lo};
            op_branch: imm = {{19{inst.b_fmt.imm_12}}, inst.b_fmt.imm_12, inst.b_fmt.imm_11,
                              inst.b_fmt.imm_10_5, inst.b_fmt.imm_4_1, 1'b0};
            default: imm = '0;
        endcase
    end

    always_comb begin
        alu_op      = alu_add;
        alu_src_imm = 1'b0;
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        branch      = 1'b0;
        reg_write   = 1'b0;
        case (inst.r_fmt.opcode)
            op_rtype, op_itype: begin
                reg_write   = 1'b1;
                alu_src_imm = (inst.r_fmt.opcode == op_itype);
                case (inst.r_fmt.funct3)
                    f3_add_sub: begin
                        // funct7 only means sub for register operands
                        if (!alu_src_imm && inst.r_fmt.funct7 == f7_sub) begin
                            alu_op = alu_sub;
                        end
                    end
                    f3_slt:  alu_op = alu_slt;
                    f3_or:   alu_op = alu_or;
                    f3_and:  alu_op = alu_and;
                    default: reg_write = 1'b0;
                endcase
            end
            op_load: begin
                alu_src_imm = 1'b1;
                mem_read    = 1'b1;
                reg_write   = 1'b1;
            end
            op_store: begin
                alu_src_imm = 1'b1;
                mem_write   = 1'b1;
            end
            op_branch: begin
                alu_op = alu_sub;
                branch = (inst.b_fmt.funct3 == f3_beq);
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (wb_valid && wb_rd != '0) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // Same-cycle writeback bypasses the array
    assign rdata1 = (rs1 == '0) ? '0 : (wb_valid && wb_rd == rs1) ? wb_data : regs[rs1];
    assign rdata2 = (rs2 == '0) ? '0 : (wb_valid && wb_rd == rs2) ? wb_data : regs[rs2];

    // Load in EX feeding the instruction in ID
    assign stall = id_valid && ex_valid && ex_mem_read && ex_rd != '0 &&
                   (ex_rd == rs1 || ex_rd == rs2);

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= id_valid && !flush && !stall;
        end
    end

    always_ff @(posedge clk) begin
        if (!flush) begin
            ex_pc          <= id_pc;
            ex_rs1         <= rs1;
            ex_rs2         <= rs2;
            ex_rd          <= inst.r_fmt.rd;
            ex_imm         <= imm;
            ex_rdata1      <= rdata1;
            ex_rdata2      <= rdata2;
            ex_alu_op      <= alu_op;
            ex_alu_src_imm <= alu_src_imm;
            ex_mem_read    <= mem_read;
            ex_mem_write   <= mem_write;
            ex_branch      <= branch;
            ex_reg_write   <= reg_write;
        end
    end

    // Fetch keeps the same real instruction in IF/ID across a load-use stall
    assert property (@(posedge clk) disable iff (rst)
        (stall && !flush) |=> (id_valid && $stable(id_inst)));

endmodule

// File: logic/if_stage.sv
`timescale 1ns/100ps

module if_stage import cpu_pkg::*; #(
    parameter int imem_depth = 64
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          prog_we,
    input  logic [$clog2(imem_depth)-1:0] prog_addr,
    input  logic [xlen-1:0]               prog_data,
    input  logic                          stall,
    input  logic                          branch_taken,
    input  logic [xlen-1:0]               target,
    output logic                          id_valid,
    output logic [xlen-1:0]               id_pc,
    output logic [xlen-1:0]               id_inst
);

    localparam int iaw = $clog2(imem_depth);

    logic [xlen-1:0] pc;
    logic [xlen-1:0] imem [imem_depth];
    logic [xlen-1:0] fetch_word;

    // Program load, only while the core sits in reset
    always_ff @(posedge clk) begin
        if (rst && prog_we) begin
            imem[prog_addr] <= prog_data;
        end
    end

    // Word addressed, low two PC bits ignored
    assign fetch_word = imem[pc[iaw+1:2]];

    // Redirect wins over stall
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else if (branch_taken) begin
            pc <= target;
        end else if (!stall) begin
            pc <= pc + xlen'(4);
        end
    end

    // IF/ID valid, cleared by a taken branch
    always_ff @(posedge clk) begin
        if (rst) begin
            id_valid <= 1'b0;
        end else if (branch_taken) begin
            id_valid <= 1'b0;
        end else if (!stall) begin
            id_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!branch_taken && !stall) begin
            id_pc   <= pc;
            id_inst <= fetch_word;
        end
    end

endmodule

// File: logic/mem_stage.sv
`timescale 1ns/100ps

module mem_stage import cpu_pkg::*; #(
    parameter int dmem_depth = 64
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              mem_valid,
    input  logic [xlen-1:0]   mem_alu_result,
    input  logic [xlen-1:0]   mem_store_data,
    input  logic [xlen-1:0]   mem_target,
    input  logic              mem_zero,
    input  logic [reg_aw-1:0] mem_rd,
    input  logic              mem_mem_read,
    input  logic              mem_mem_write,
    input  logic              mem_branch,
    input  logic              mem_reg_write,
    output logic              branch_taken,
    output logic [xlen-1:0]   target,
    output logic              wb_valid,
    output logic [reg_aw-1:0] wb_rd,
    output logic [xlen-1:0]   wb_data,
    output logic              st_valid,
    output logic [xlen-1:0]   st_addr,
    output logic [xlen-1:0]   st_data
);

    localparam int daw = $clog2(dmem_depth);

    logic [xlen-1:0] dmem [dmem_depth];
    logic [daw-1:0]  dmem_idx;
    logic [xlen-1:0] load_data;
    logic            wb_is_load;
    logic [xlen-1:0] wb_load_data;
    logic [xlen-1:0] wb_alu_result;

    assign dmem_idx  = mem_alu_result[daw+1:2];
    assign load_data = dmem[dmem_idx];

    always_ff @(posedge clk) begin
        if (st_valid) begin
            dmem[dmem_idx] <= mem_store_data;
        end
    end

    // beq resolves here, zero came from rs1 - rs2
    assign branch_taken = mem_valid && mem_branch && mem_zero;
    assign target       = mem_target;

    // Store trace in the write cycle
    assign st_valid = mem_valid && mem_mem_write;
    assign st_addr  = mem_alu_result;
    assign st_data  = mem_store_data;

    // Writes to x0 never reach the trace
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= mem_valid && mem_reg_write && mem_rd != '0;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd         <= mem_rd;
        wb_is_load    <= mem_mem_read;
        wb_load_data  <= load_data;
        wb_alu_result <= mem_alu_result;
    end

    assign wb_data = wb_is_load ? wb_load_data : wb_alu_result;

    assert property (@(posedge clk) disable iff (rst)
        (mem_valid && (mem_mem_read || mem_mem_write)) |-> (mem_alu_result[1:0] == 2'b00));

endmodule

// File: logic/top_cpu.sv
`timescale 1ns/100ps

module top_cpu import cpu_pkg::*; #(
    parameter int imem_depth = 64,
    parameter int dmem_depth = 64
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          prog_we,
    input  logic [$clog2(imem_depth)-1:0] prog_addr,
    input  logic [xlen-1:0]               prog_data,
    output logic                          wb_valid,
    output logic [reg_aw-1:0]             wb_rd,
    output logic [xlen-1:0]               wb_data,
    output logic                          st_valid,
    output logic [xlen-1:0]               st_addr,
    output logic [xlen-1:0]               st_data
);

    // Fetch to decode
    logic              id_valid;
    logic [xlen-1:0]   id_pc;
    logic [xlen-1:0]   id_inst;
    logic              stall;

    // Decode to execute
    logic              ex_valid;
    logic [xlen-1:0]   ex_pc;
    logic [reg_aw-1:0] ex_rs1;
    logic [reg_aw-1:0] ex_rs2;
    logic [reg_aw-1:0] ex_rd;
    logic [xlen-1:0]   ex_imm;
    logic [xlen-1:0]   ex_rdata1;
    logic [xlen-1:0]   ex_rdata2;
    alu_op_t           ex_alu_op;
    logic              ex_alu_src_imm;
    logic              ex_mem_read;
    logic              ex_mem_write;
    logic              ex_branch;
    logic              ex_reg_write;

    // Execute to memory
    logic              mem_valid;
    logic [xlen-1:0]   mem_alu_result;
    logic [xlen-1:0]   mem_store_data;
    logic [xlen-1:0]   mem_target;
    logic              mem_zero;
    logic [reg_aw-1:0] mem_rd;
    logic              mem_mem_read;
    logic              mem_mem_write;
    logic              mem_branch;
    logic              mem_reg_write;

    // Redirect from the memory stage
    logic              branch_taken;
    logic [xlen-1:0]   target;

    if_stage #(.imem_depth(imem_depth)) if_stage0 (.*);

    // A taken branch flushes the younger stages
    id_stage id_stage0 (
        .flush(branch_taken),
        .*
    );

    ex_stage ex_stage0 (
        .flush(branch_taken),
        .*
    );

    mem_stage #(.dmem_depth(dmem_depth)) mem_stage0 (.*);

endmodule

// File: run_sim.sh
#!/bin/sh
# Build the top_cpu testbench with Verilator, run it, and check the log

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -j 0 \
    -f top_cpu.f \
    --top-module tb_top_cpu \
    --Mdir "$build_dir" \
    -o sim_top_cpu
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

"./$build_dir/sim_top_cpu" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation FAILED" "$log_file"; then
    exit 1
fi
exit 0

// File: testbench/tb_top_cpu.sv
`timescale 1ns/100ps

module tb_top_cpu;

    localparam int imem_depth   = 64;
    localparam int dmem_depth   = 64;
    localparam int iaw          = $clog2(imem_depth);
    localparam int golden_words = 256;
    // Section offsets inside the golden image
    localparam int prog_base    = 'h10;
    localparam int wb_base      = 'h40;
    localparam int st_base      = 'h80;
    localparam int drain_cycles = 20;

    logic            clk;
    logic            rst;
    logic            prog_we;
    logic [iaw-1:0]  prog_addr;
    logic [31:0]     prog_data;
    logic            wb_valid;
    logic [4:0]      wb_rd;
    logic [31:0]     wb_data;
    logic            st_valid;
    logic [31:0]     st_addr;
    logic [31:0]     st_data;

    logic [31:0] golden [golden_words];
    int          prog_len;
    int          n_wb;
    int          n_st;
    int          wb_seen;
    int          st_seen;
    int          wb_errors;
    int          st_errors;
    int          other_errors;
    int          cycle_count;
    int          cycle_limit;

    top_cpu #(
        .imem_depth(imem_depth),
        .dmem_depth(dmem_depth)
    ) dut0 (
        .clk      (clk),
        .rst      (rst),
        .prog_we  (prog_we),
        .prog_addr(prog_addr),
        .prog_data(prog_data),
        .wb_valid (wb_valid),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data),
        .st_valid (st_valid),
        .st_addr  (st_addr),
        .st_data  (st_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    // Program words go in one per cycle, driven on the falling edge
    task automatic load_program();
        for (int i = 0; i < prog_len; i++) begin
            prog_we   = 1'b1;
            prog_addr = iaw'(i);
            prog_data = golden[prog_base + i];
            @(negedge clk);
        end
        prog_we = 1'b0;
    endtask

    task automatic compare_writeback();
        logic [31:0] exp_rd;
        logic [31:0] exp_data;
        if (wb_seen >= n_wb) begin
            $display("extra writeback to x%0d with data %h after the expected sequence",
                     wb_rd, wb_data);
            wb_errors++;
        end else begin
            exp_rd   = golden[wb_base + 2 * wb_seen];
            exp_data = golden[wb_base + 2 * wb_seen + 1];
            if ({27'b0, wb_rd} !== exp_rd) begin
                $display("mismatch writeback %0d rd: expected %0d, actual %0d",
                         wb_seen, exp_rd, wb_rd);
                wb_errors++;
            end
            if (wb_data !== exp_data) begin
                $display("mismatch writeback %0d data: expected %h, actual %h",
                         wb_seen, exp_data, wb_data);
                wb_errors++;
            end
        end
        wb_seen++;
    endtask

    task automatic verify_store();
        logic [31:0] exp_addr;
        logic [31:0] exp_data;
        if (st_seen >= n_st) begin
            $display("extra store to %h with data %h after the expected sequence",
                     st_addr, st_data);
            st_errors++;
        end else begin
            exp_addr = golden[st_base + 2 * st_seen];
            exp_data = golden[st_base + 2 * st_seen + 1];
            if (st_addr !== exp_addr) begin
                $display("mismatch store %0d address: expected %h, actual %h",
                         st_seen, exp_addr, st_addr);
                st_errors++;
            end
            if (st_data !== exp_data) begin
                $display("mismatch store %0d data: expected %h, actual %h",
                         st_seen, exp_data, st_data);
                st_errors++;
            end
        end
        st_seen++;
    endtask

    // Trace ports hold registered values across the rising edge
    always @(posedge clk) begin
        if (!rst && wb_valid) begin
            compare_writeback();
        end
        if (!rst && st_valid) begin
            verify_store();
        end
    end

    initial begin
        int idle;
        rst          = 1'b1;
        prog_we      = 1'b0;
        prog_addr    = '0;
        prog_data    = '0;
        wb_seen      = 0;
        st_seen      = 0;
        wb_errors    = 0;
        st_errors    = 0;
        other_errors = 0;
        cycle_count  = 0;
        void'($urandom(32'hb006_a215));

        $readmemh("testbench/top_cpu_golden.txt", golden);
        prog_len    = golden[0];
        n_wb        = golden[1];
        n_st        = golden[2];
        cycle_limit = (prog_len + n_wb) * 4 + 50;
        if (prog_len == 0 || prog_len > imem_depth) begin
            $display("golden file gave a program length of %0d words, which cannot run",
                     prog_len);
            other_errors++;
        end

        repeat (2) @(negedge clk);
        load_program();
        // Random extra cycles in reset before the core starts
        idle = $urandom % 8;
        repeat (idle) @(negedge clk);
        rst = 1'b0;

        while ((wb_seen < n_wb || st_seen < n_st) && cycle_count < cycle_limit) begin
            @(negedge clk);
        end
        if (cycle_count >= cycle_limit) begin
            $display("timeout after %0d cycles: saw %0d of %0d writebacks, %0d of %0d stores",
                     cycle_count, wb_seen, n_wb, st_seen, n_st);
            other_errors++;
        end else begin
            // The program ends in a self loop, so nothing more may appear
            repeat (drain_cycles) @(negedge clk);
        end

        $display("errors: writeback %0d, store %0d, other %0d",
                 wb_errors, st_errors, other_errors);
        if (wb_errors + st_errors + other_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: testbench/top_cpu_golden.txt
// 0x000: program words, writebacks, stores. 0x010: program words.
// 0x040: writeback (rd, data) pairs. 0x080: store (address, data) pairs.
@000
0000001e 00000013 00000002
@010
00c00093 ffb00113 // addi x1,x0,12    addi x2,x0,-5
00700193 80000213 // addi x3,x0,7     addi x4,x0,-2048
0030f3b3 0030e433 // and x7,x1,x3     or x8,x1,x3
001124b3 0020a533 // slt x9,x2,x1     slt x10,x1,x2
003082b3 40308333 // add x5,x1,x3     sub x6,x1,x3
006285b3 40258633 // add x11,x5,x6    sub x12,x11,x2
004606b3 00b0a423 // add x13,x12,x4   sw x11,8(x1)
fed0ae23 01402703 // sw x13,-4(x1)    lw x14,20(x0)
003707b3 00802803 // add x15,x14,x3   lw x16,8(x0)
010188b3 00628663 // add x17,x3,x16   beq x5,x6,+12 not taken
06400913 00e58863 // addi x18,x0,100  beq x11,x14,+16 taken
00100993 00200a13 // wrong path: addi x19,x0,1  addi x20,x0,2
00300a93 fff90b13 // wrong path: addi x21,x0,3  then addi x22,x18,-1
00000063 00000013 // beq x0,x0,0 self loop, nop
00000013 00000013 // nop nop
@040
01 0000000c 02 fffffffb
03 00000007 04 fffff800
07 00000004 08 0000000f
09 00000001 0a 00000000
05 00000013 06 00000005
0b 00000018 0c 0000001d
0d fffff81d 0e 00000018
0f 0000001f 10 fffff81d
11 fffff824 12 00000064
16 00000063
@080
00000014 00000018
00000008 fffff81d

// File: top_cpu.f
logic/cpu_pkg.sv
logic/if_stage.sv
logic/id_stage.sv
logic/ex_stage.sv
logic/mem_stage.sv
logic/top_cpu.sv
testbench/tb_top_cpu.sv
